/* Makefile */
# Verilator build and run for the tile bus testbench

VERILATOR ?= verilator
TOP       ?= tb_tile_top
OBJ_DIR   ?= obj_dir
FLIST     ?= flist.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(wildcard src/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Exit status of the binary is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
+incdir+sim
src/tile_pkg.sv
src/wb_if.sv
src/tile_bus_ctrl.sv
src/tile_spram.sv
src/tile_uart_regs.sv
src/tile_top.sv
sim/tb_tile_top.sv

/* sim/tb_tile_checks.svh */
`ifndef TB_TILE_CHECKS_SVH
`define TB_TILE_CHECKS_SVH

// Ends the run at the first failure
task automatic report_fail(input string msg);
  $display("%s", msg);
  $display("Simulation failed");
  $fatal(1, "stopped at first failure");
endtask

task automatic check_dat(input string name, input wb_dat_t exp, input wb_dat_t act);
  if (act !== exp) begin
    report_fail($sformatf("ERR %s expected 0x%h actual 0x%h", name, exp, act));
  end
endtask

// Response as {ack, err}
task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
  if (act !== exp) begin
    report_fail($sformatf("ERR %s {ack,err} expected 0x%h actual 0x%h", name, exp, act));
  end
endtask

task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
  if (act !== exp) begin
    report_fail($sformatf("ERR %s expected 0x%h actual 0x%h", name, exp, act));
  end
endtask

task automatic check_irq(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    report_fail($sformatf("ERR %s expected 0x%h actual 0x%h", name, exp, act));
  end
endtask

`endif

/* sim/tb_tile_top.sv */
`timescale 1ns/100ps

module tb_tile_top import tile_pkg::*; ();

  localparam int RST_CYCLES = 5;
  localparam int N_MEM      = 60;
  localparam int N_UART     = 30;
  localparam int N_BAD      = 12;
  localparam int N_ROUNDS   = 40;
  localparam int N_TXN      = N_MEM + N_UART + N_BAD + N_ROUNDS * N_MASTERS;
  localparam int TIMEOUT    = N_TXN * N_MASTERS * 8 + RST_CYCLES;
  localparam int K_MEM      = 0;
  localparam int K_UART     = 1;
  localparam int K_BAD      = 2;

  logic                    wb_clk = 1'b0;
  logic                    arst_n;
  wb_adr_u [N_MASTERS-1:0] adr_d;
  wb_dat_t [N_MASTERS-1:0] wdat_d;
  wb_sel_t [N_MASTERS-1:0] sel_d;
  logic    [N_MASTERS-1:0] we_d;
  logic    [N_MASTERS-1:0] cyc_d;
  logic    [N_MASTERS-1:0] stb_d;
  wb_dat_t [N_MASTERS-1:0] rdat_w;
  logic    [N_MASTERS-1:0] ack_w;
  logic    [N_MASTERS-1:0] err_w;
  logic    [7:0]           tx_byte;
  logic                    uart_irq;
  logic    [31:0]          rng = 32'h98b47dbc;
  int                      cycle_cnt = 0;
  int                      done_cyc [N_MASTERS];

  // Reference model
  wb_dat_t                 mem_m [MEM_WORDS];
  bit                      vld_m [MEM_WORDS];
  logic    [7:0]           thr_m;
  logic    [7:0]           ier_m;
  logic    [7:0]           scr_m;

  `include "tb_tile_checks.svh"

  tile_top DUT (
    .wb_clk_i   (wb_clk),
    .arst_n_i   (arst_n),
    .ibus_adr_i (adr_d[M_IBUS]),
    .ibus_dat_i (wdat_d[M_IBUS]),
    .ibus_sel_i (sel_d[M_IBUS]),
    .ibus_we_i  (we_d[M_IBUS]),
    .ibus_cyc_i (cyc_d[M_IBUS]),
    .ibus_stb_i (stb_d[M_IBUS]),
    .ibus_dat_o (rdat_w[M_IBUS]),
    .ibus_ack_o (ack_w[M_IBUS]),
    .ibus_err_o (err_w[M_IBUS]),
    .dbus_adr_i (adr_d[M_DBUS]),
    .dbus_dat_i (wdat_d[M_DBUS]),
    .dbus_sel_i (sel_d[M_DBUS]),
    .dbus_we_i  (we_d[M_DBUS]),
    .dbus_cyc_i (cyc_d[M_DBUS]),
    .dbus_stb_i (stb_d[M_DBUS]),
    .dbus_dat_o (rdat_w[M_DBUS]),
    .dbus_ack_o (ack_w[M_DBUS]),
    .dbus_err_o (err_w[M_DBUS]),
    .dbg_adr_i  (adr_d[M_DBG]),
    .dbg_dat_i  (wdat_d[M_DBG]),
    .dbg_sel_i  (sel_d[M_DBG]),
    .dbg_we_i   (we_d[M_DBG]),
    .dbg_cyc_i  (cyc_d[M_DBG]),
    .dbg_stb_i  (stb_d[M_DBG]),
    .dbg_dat_o  (rdat_w[M_DBG]),
    .dbg_ack_o  (ack_w[M_DBG]),
    .dbg_err_o  (err_w[M_DBG]),
    .tx_byte_o  (tx_byte),
    .uart_irq_o (uart_irq)
  );

  always #50 wb_clk = ~wb_clk;

  always @(posedge wb_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      report_fail($sformatf("Timeout after %0d cycles, the run hung", cycle_cnt));
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x   = rng;
    x   = x ^ (x << 13);
    x   = x ^ (x >> 17);
    x   = x ^ (x << 5);
    rng = x;
    return x;
  endfunction

  function automatic string port_pfx(input int m);
    case (m)
      M_DBG:   return "dbg";
      M_DBUS:  return "dbus";
      default: return "ibus";
    endcase
  endfunction

  task automatic make_req(input int kind, output wb_adr_u adr, output logic we,
                          output wb_dat_t dat, output wb_sel_t sel);
    logic [31:0] r;
    r   = xorshift32();
    adr = xorshift32();
    dat = xorshift32();
    we  = r[0];
    sel = r[4:1];
    case (kind)
      K_MEM: begin
        adr.mem.region = REGION_MEM;
        adr.mem.idx    = {r[9:7], 5'b0, r[6:5]};
        // Unknown word gets a full write first
        if (!vld_m[adr.mem.idx]) begin
          we  = 1'b1;
          sel = '1;
        end
      end
      K_UART: adr.uart.region = REGION_UART;
      default: begin
        // Same words and registers that the other accesses use
        adr.mem.idx    = {r[9:7], 5'b0, r[6:5]};
        adr.mem.region = r[13:10];
        if (r[13:10] inside {REGION_MEM, REGION_UART}) begin
          adr.mem.region = r[13:10] ^ 4'h5;
        end
      end
    endcase
  endtask

  task automatic model_access(input wb_adr_u adr, input logic we, input wb_dat_t dat,
                              input wb_sel_t sel, output wb_dat_t exp_dat,
                              output logic [1:0] exp_resp);
    logic [MEM_IDX_W-1:0] idx;
    idx      = adr.mem.idx;
    exp_dat  = '0;
    exp_resp = 2'b10;
    if (adr.mem.region == 4'h0) begin
      exp_dat = mem_m[idx];
      if (we) begin
        for (int b = 0; b < 4; b++) begin
          if (sel[b]) begin
            mem_m[idx][8*b +: 8] = dat[8*b +: 8];
          end
        end
        vld_m[idx] = 1'b1;
      end
    end else if (adr.uart.region == 4'h9) begin
      case (adr.uart.reg_off)
        3'd0:    exp_dat[7:0] = thr_m;
        3'd1:    exp_dat[7:0] = ier_m;
        3'd5:    exp_dat[7:0] = 8'h60;
        3'd7:    exp_dat[7:0] = scr_m;
        default: exp_dat[7:0] = 8'h00;
      endcase
      if (we) begin
        case (adr.uart.reg_off)
          3'd0:    thr_m = dat[7:0];
          3'd1:    ier_m = dat[7:0];
          3'd7:    scr_m = dat[7:0];
          default: ;
        endcase
      end
    end else begin
      exp_resp = 2'b01;
    end
  endtask

  //////////////////////////////////////////////////
  // Wishbone classic master driver
  //////////////////////////////////////////////////
  task automatic bus_access(input int m, input wb_adr_u adr, input logic we,
                            input wb_dat_t dat, input wb_sel_t sel,
                            output wb_dat_t rdat, output logic [1:0] resp);
    adr_d[m]  = adr;
    wdat_d[m] = dat;
    sel_d[m]  = sel;
    we_d[m]   = we;
    cyc_d[m]  = 1'b1;
    stb_d[m]  = 1'b1;
    @(posedge wb_clk);
    #1;
    while (!(ack_w[m] || err_w[m])) begin
      @(posedge wb_clk);
      #1;
    end
    rdat        = rdat_w[m];
    resp        = {ack_w[m], err_w[m]};
    done_cyc[m] = cycle_cnt;
    cyc_d[m]    = 1'b0;
    stb_d[m]    = 1'b0;
    // Idle cycle between requests, no second response
    @(posedge wb_clk);
    #1;
    check_resp($sformatf("%s_ack_o/err_o idle", port_pfx(m)), 2'b00, {ack_w[m], err_w[m]});
  endtask

  task automatic check_result(input int m, input logic we, input wb_dat_t exp_dat,
                              input logic [1:0] exp_resp, input wb_dat_t rdat,
                              input logic [1:0] resp);
    check_resp($sformatf("%s_ack_o/err_o", port_pfx(m)), exp_resp, resp);
    if (!we && exp_resp == 2'b10) begin
      check_dat($sformatf("%s_dat_o", port_pfx(m)), exp_dat, rdat);
    end
    check_byte("tx_byte_o", thr_m, tx_byte);
    check_irq("uart_irq_o", ier_m[1], uart_irq);
  endtask

  task automatic run_one(input int m, input int kind);
    wb_adr_u    adr;
    logic       we;
    wb_dat_t    dat;
    wb_dat_t    rdat;
    wb_dat_t    exp_dat;
    wb_sel_t    sel;
    logic [1:0] resp;
    logic [1:0] exp_resp;
    make_req(kind, adr, we, dat, sel);
    model_access(adr, we, dat, sel, exp_dat, exp_resp);
    bus_access(m, adr, we, dat, sel, rdat, resp);
    check_result(m, we, exp_dat, exp_resp, rdat, resp);
  endtask

  // All active masters start on the same edge
  task automatic run_round();
    logic [31:0]          r;
    logic [N_MASTERS-1:0] act;
    logic [1:0]           k;
    wb_adr_u              adr [N_MASTERS];
    logic                 we [N_MASTERS];
    wb_dat_t              dat [N_MASTERS];
    wb_dat_t              rdat [N_MASTERS];
    wb_dat_t              exp_dat [N_MASTERS];
    wb_sel_t              sel [N_MASTERS];
    logic [1:0]           resp [N_MASTERS];
    logic [1:0]           exp_resp [N_MASTERS];
    r   = xorshift32();
    act = r[2:0];
    if (act == '0) begin
      act = '1;
    end
    // Model follows the priority order
    for (int m = 0; m < N_MASTERS; m++) begin
      if (act[m]) begin
        k = r[3+2*m +: 2];
        make_req((k == 2'd3) ? K_BAD : (k == 2'd2) ? K_UART : K_MEM, adr[m], we[m],
                 dat[m], sel[m]);
        model_access(adr[m], we[m], dat[m], sel[m], exp_dat[m], exp_resp[m]);
      end
    end
    fork
      if (act[M_DBG]) bus_access(M_DBG, adr[M_DBG], we[M_DBG], dat[M_DBG], sel[M_DBG],
                                 rdat[M_DBG], resp[M_DBG]);
      if (act[M_DBUS]) bus_access(M_DBUS, adr[M_DBUS], we[M_DBUS], dat[M_DBUS],
                                  sel[M_DBUS], rdat[M_DBUS], resp[M_DBUS]);
      if (act[M_IBUS]) bus_access(M_IBUS, adr[M_IBUS], we[M_IBUS], dat[M_IBUS],
                                  sel[M_IBUS], rdat[M_IBUS], resp[M_IBUS]);
    join
    for (int m = 0; m < N_MASTERS; m++) begin
      if (act[m]) begin
        check_result(m, we[m], exp_dat[m], exp_resp[m], rdat[m], resp[m]);
        for (int h = 0; h < m; h++) begin
          if (act[h] && done_cyc[h] >= done_cyc[m]) begin
            report_fail($sformatf("Master %s finished no later than higher priority %s",
                                  port_pfx(m), port_pfx(h)));
          end
        end
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    adr_d  = '0;
    wdat_d = '0;
    sel_d  = '0;
    we_d   = '0;
    cyc_d  = '0;
    stb_d  = '0;
    thr_m  = '0;
    ier_m  = '0;
    scr_m  = '0;
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge wb_clk);
    #1;
    arst_n = 1'b1;

    // Quiet bus after reset
    repeat (4) begin
      @(posedge wb_clk);
      #1;
      for (int m = 0; m < N_MASTERS; m++) begin
        check_resp($sformatf("%s_ack_o/err_o", port_pfx(m)), 2'b00, {ack_w[m], err_w[m]});
      end
    end
    check_byte("tx_byte_o", 8'h00, tx_byte);
    check_irq("uart_irq_o", 1'b0, uart_irq);

    for (int i = 0; i < N_MEM; i++) begin
      run_one(int'(xorshift32() % 32'd3), K_MEM);
    end
    for (int i = 0; i < N_UART; i++) begin
      run_one(int'(xorshift32() % 32'd3), K_UART);
    end
    for (int i = 0; i < N_BAD; i++) begin
      run_one(int'(xorshift32() % 32'd3), K_BAD);
    end
    for (int i = 0; i < N_ROUNDS; i++) begin
      run_round();
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

/* src/tile_bus_ctrl.sv */
`timescale 1ns/100ps

module tile_bus_ctrl import tile_pkg::*; (
  input  logic                    wb_clk_i,
  input  logic                    arst_n_i,
  input  logic    [N_MASTERS-1:0] cyc_i,
  input  logic    [N_MASTERS-1:0] stb_i,
  input  logic    [N_MASTERS-1:0] we_i,
  input  wb_adr_u [N_MASTERS-1:0] adr_i,
  input  wb_dat_t [N_MASTERS-1:0] dat_i,
  input  wb_sel_t [N_MASTERS-1:0] sel_i,
  output wb_dat_t [N_MASTERS-1:0] dat_o,
  output logic    [N_MASTERS-1:0] ack_o,
  output logic    [N_MASTERS-1:0] err_o,
  wb_if.master                    ram_m,
  wb_if.master                    uart_m
);

  logic [N_MASTERS-1:0] req;
  logic [N_MASTERS-1:0] gnt_q;
  logic [N_MASTERS-1:0] gnt_nxt;
  logic                 gnt_any;
  wb_adr_u              m_adr;
  wb_dat_t              m_dat;
  wb_sel_t              m_sel;
  logic                 m_we;
  logic                 m_cyc;
  logic                 m_stb;
  logic                 hit_mem;
  logic                 hit_uart;
  logic                 unmapped;
  logic                 err_q;
  wb_dat_t              rsp_dat;
  logic                 rsp_ack;
  logic                 rsp_err;

  //////////////////////////////////////////////////
  // Fixed priority arbiter
  //////////////////////////////////////////////////
  assign req     = cyc_i & stb_i;
  assign gnt_any = |gnt_q;

  always_comb begin
    gnt_nxt = '0;
    if (req[M_DBG]) begin
      gnt_nxt[M_DBG] = 1'b1;
    end else if (req[M_DBUS]) begin
      gnt_nxt[M_DBUS] = 1'b1;
    end else if (req[M_IBUS]) begin
      gnt_nxt[M_IBUS] = 1'b1;
    end
  end

  // Held until the owner drops cyc
  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gnt_q <= '0;
    end else if (!gnt_any) begin
      gnt_q <= gnt_nxt;
    end else if (!m_cyc) begin
      gnt_q <= '0;
    end
  end

  // Granted master onto the shared request path
  always_comb begin
    m_adr = '0;
    m_dat = '0;
    m_sel = '0;
    m_we  = 1'b0;
    m_cyc = 1'b0;
    m_stb = 1'b0;
    for (int i = 0; i < N_MASTERS; i++) begin
      if (gnt_q[i]) begin
        m_adr = adr_i[i];
        m_dat = dat_i[i];
        m_sel = sel_i[i];
        m_we  = we_i[i];
        m_cyc = cyc_i[i];
        m_stb = stb_i[i];
      end
    end
  end

  //////////////////////////////////////////////////
  // Address decode and slave requests
  //////////////////////////////////////////////////
  assign hit_mem  = (m_adr.mem.region == REGION_MEM);
  assign hit_uart = (m_adr.uart.region == REGION_UART);
  assign unmapped = !hit_mem && !hit_uart;

  assign ram_m.adr   = m_adr;
  assign ram_m.dat_w = m_dat;
  assign ram_m.sel   = m_sel;
  assign ram_m.we    = m_we;
  assign ram_m.cyc   = m_cyc && hit_mem;
  assign ram_m.stb   = m_stb && hit_mem;

  assign uart_m.adr   = m_adr;
  assign uart_m.dat_w = m_dat;
  assign uart_m.sel   = m_sel;
  assign uart_m.we    = m_we;
  assign uart_m.cyc   = m_cyc && hit_uart;
  assign uart_m.stb   = m_stb && hit_uart;

  // Unmapped region, one err pulse per request
  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= m_cyc && m_stb && unmapped && !err_q;
    end
  end

  //////////////////////////////////////////////////
  // Response steering
  //////////////////////////////////////////////////
  assign rsp_dat = hit_uart ? uart_m.dat_r : ram_m.dat_r;
  assign rsp_ack = (hit_mem && ram_m.ack) || (hit_uart && uart_m.ack);
  assign rsp_err = err_q || (hit_mem && ram_m.err) || (hit_uart && uart_m.err);

  always_comb begin
    for (int i = 0; i < N_MASTERS; i++) begin
      dat_o[i] = gnt_q[i] ? rsp_dat : '0;
      ack_o[i] = gnt_q[i] && cyc_i[i] && rsp_ack;
      err_o[i] = gnt_q[i] && cyc_i[i] && rsp_err;
    end
  end

  a_gnt_onehot: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
    $onehot0(gnt_q));

  a_rsp_excl: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
    (ack_o & err_o) == '0);

  // Owner and its request stay put while waiting
  a_req_stable: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
    (gnt_any && m_stb && !(|(ack_o | err_o))) |=>
      ($stable(gnt_q) && $stable(m_adr) && $stable(m_we) &&
       $stable(m_sel) && $stable(m_dat)));

endmodule

/* src/tile_pkg.sv */
package tile_pkg;

  // Bus widths
  localparam int WB_AW = 32;
  localparam int WB_DW = 32;
  localparam int WB_SW = 4;

  // RAM geometry
  localparam int MEM_WORDS = 1024;
  localparam int MEM_IDX_W = 10;

  // Top address nibble
  localparam logic [3:0] REGION_MEM  = 4'h0;
  localparam logic [3:0] REGION_UART = 4'h9;

  // 16550 register offsets, byte lane 0
  localparam logic [2:0] UART_THR = 3'd0;
  localparam logic [2:0] UART_IER = 3'd1;
  localparam logic [2:0] UART_LSR = 3'd5;
  localparam logic [2:0] UART_SCR = 3'd7;

  // THR empty and transmitter empty
  localparam logic [7:0] LSR_IDLE = 8'h60;

  // Masters, lowest index wins
  localparam int N_MASTERS = 3;
  localparam int M_DBG     = 0;
  localparam int M_DBUS    = 1;
  localparam int M_IBUS    = 2;

  typedef logic [WB_DW-1:0] wb_dat_t;
  typedef logic [WB_SW-1:0] wb_sel_t;

  typedef union packed {
    struct packed {
      logic [3:0]                     region;
      logic [WB_AW-4-MEM_IDX_W-3:0]   unused;
      logic [MEM_IDX_W-1:0]           idx;
      logic [1:0]                     byte_off;
    } mem;
    struct packed {
      logic [3:0]                     region;
      logic [WB_AW-4-3-3:0]           unused;
      logic [2:0]                     reg_off;
      logic [1:0]                     byte_off;
    } uart;
  } wb_adr_u;

endpackage

/* src/tile_spram.sv */
`timescale 1ns/100ps

module tile_spram import tile_pkg::*; (
  input  logic wb_clk_i,
  input  logic arst_n_i,
  wb_if.slave  bus_s
);

  wb_dat_t              mem [MEM_WORDS];
  logic [MEM_IDX_W-1:0] idx;
  logic                 req;
  logic                 ack_q;
  wb_dat_t              rdat_q;

  assign idx = bus_s.adr.mem.idx;

  // No new request while the ack is out
  assign req = bus_s.cyc && bus_s.stb && !ack_q;

  // Byte lane writes
  always_ff @(posedge wb_clk_i) begin
    if (req && bus_s.we) begin
      for (int b = 0; b < WB_SW; b++) begin
        if (bus_s.sel[b]) begin
          mem[idx][8*b +: 8] <= bus_s.dat_w[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (req) begin
      rdat_q <= mem[idx];
    end
  end

  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  assign bus_s.dat_r = rdat_q;
  assign bus_s.ack   = ack_q;
  assign bus_s.err   = 1'b0;

  a_ack_single: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
    ack_q |=> !ack_q);

endmodule

/* src/tile_top.sv */
`timescale 1ns/100ps

module tile_top import tile_pkg::*; (
  input  logic             wb_clk_i,
  input  logic             arst_n_i,

  // Instruction bus
  input  logic [WB_AW-1:0] ibus_adr_i,
  input  wb_dat_t          ibus_dat_i,
  input  wb_sel_t          ibus_sel_i,
  input  logic             ibus_we_i,
  input  logic             ibus_cyc_i,
  input  logic             ibus_stb_i,
  output wb_dat_t          ibus_dat_o,
  output logic             ibus_ack_o,
  output logic             ibus_err_o,

  // Data bus
  input  logic [WB_AW-1:0] dbus_adr_i,
  input  wb_dat_t          dbus_dat_i,
  input  wb_sel_t          dbus_sel_i,
  input  logic             dbus_we_i,
  input  logic             dbus_cyc_i,
  input  logic             dbus_stb_i,
  output wb_dat_t          dbus_dat_o,
  output logic             dbus_ack_o,
  output logic             dbus_err_o,

  // Debug bus
  input  logic [WB_AW-1:0] dbg_adr_i,
  input  wb_dat_t          dbg_dat_i,
  input  wb_sel_t          dbg_sel_i,
  input  logic             dbg_we_i,
  input  logic             dbg_cyc_i,
  input  logic             dbg_stb_i,
  output wb_dat_t          dbg_dat_o,
  output logic             dbg_ack_o,
  output logic             dbg_err_o,

  output logic [7:0]       tx_byte_o,
  output logic             uart_irq_o
);

  wb_if ram_bus ();
  wb_if uart_bus ();

  //////////////////////////////////////////////////
  // Interconnect, packed as {ibus, dbus, dbg}
  //////////////////////////////////////////////////
  tile_bus_ctrl bus_ctrl0 (
    .wb_clk_i (wb_clk_i),
    .arst_n_i (arst_n_i),
    .cyc_i    ({ibus_cyc_i, dbus_cyc_i, dbg_cyc_i}),
    .stb_i    ({ibus_stb_i, dbus_stb_i, dbg_stb_i}),
    .we_i     ({ibus_we_i,  dbus_we_i,  dbg_we_i}),
    .adr_i    ({ibus_adr_i, dbus_adr_i, dbg_adr_i}),
    .dat_i    ({ibus_dat_i, dbus_dat_i, dbg_dat_i}),
    .sel_i    ({ibus_sel_i, dbus_sel_i, dbg_sel_i}),
    .dat_o    ({ibus_dat_o, dbus_dat_o, dbg_dat_o}),
    .ack_o    ({ibus_ack_o, dbus_ack_o, dbg_ack_o}),
    .err_o    ({ibus_err_o, dbus_err_o, dbg_err_o}),
    .ram_m    (ram_bus.master),
    .uart_m   (uart_bus.master)
  );

  tile_spram spram0 (
    .wb_clk_i (wb_clk_i),
    .arst_n_i (arst_n_i),
    .bus_s    (ram_bus.slave)
  );

  tile_uart_regs uart0 (
    .wb_clk_i   (wb_clk_i),
    .arst_n_i   (arst_n_i),
    .bus_s      (uart_bus.slave),
    .tx_byte_o  (tx_byte_o),
    .uart_irq_o (uart_irq_o)
  );

endmodule

/* src/tile_uart_regs.sv */
`timescale 1ns/100ps

module tile_uart_regs import tile_pkg::*; (
  input  logic       wb_clk_i,
  input  logic       arst_n_i,
  wb_if.slave        bus_s,
  output logic [7:0] tx_byte_o,
  output logic       uart_irq_o
);

  logic [2:0] reg_off;
  logic       req;
  logic       ack_q;
  logic [7:0] thr_q;
  logic [7:0] ier_q;
  logic [7:0] scr_q;
  logic [7:0] rd_byte;
  logic [7:0] rd_q;

  assign reg_off = bus_s.adr.uart.reg_off;
  assign req     = bus_s.cyc && bus_s.stb && !ack_q;

  // Register writes, data lane 0
  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      thr_q <= '0;
      ier_q <= '0;
      scr_q <= '0;
    end else if (req && bus_s.we) begin
      case (reg_off)
        UART_THR: thr_q <= bus_s.dat_w[7:0];
        UART_IER: ier_q <= bus_s.dat_w[7:0];
        UART_SCR: scr_q <= bus_s.dat_w[7:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    case (reg_off)
      UART_THR: rd_byte = thr_q;
      UART_IER: rd_byte = ier_q;
      UART_LSR: rd_byte = LSR_IDLE;
      UART_SCR: rd_byte = scr_q;
      default:  rd_byte = '0;
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (req) begin
      rd_q <= rd_byte;
    end
  end

  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  assign bus_s.dat_r = {{(WB_DW-8){1'b0}}, rd_q};
  assign bus_s.ack   = ack_q;
  assign bus_s.err   = 1'b0;

  assign tx_byte_o = thr_q;

  // Transmitter never busy, so ETBEI alone raises the line
  assign uart_irq_o = ier_q[1];

endmodule

/* src/wb_if.sv */
`timescale 1ns/100ps

interface wb_if import tile_pkg::*; ();

  wb_adr_u adr;
  wb_dat_t dat_w;
  wb_sel_t sel;
  logic    we;
  logic    cyc;
  logic    stb;
  wb_dat_t dat_r;
  logic    ack;
  logic    err;

  modport master (
    output adr, dat_w, sel, we, cyc, stb,
    input  dat_r, ack, err
  );

  modport slave (
    input  adr, dat_w, sel, we, cyc, stb,
    output dat_r, ack, err
  );

endinterface
